/* verilog.f */
+incdir+testbench
design/lane_cfg_pkg.sv
design/lane_op_pkg.sv
design/lane_sequencer.sv
design/operand_fetch.sv
design/vrf_bank_arbiter.sv
design/vector_regfile.sv
design/lane_alu.sv
design/lane_top.sv
testbench/lane_tb.sv

/* testbench/lane_tb_util.svh */
`ifndef LANE_TB_UTIL_SVH
`define LANE_TB_UTIL_SVH

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] rand32();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// Element result with sub taken as vs2 minus vs1
function automatic elen_t alu_ref(input alu_op_e op, input elen_t a_vs2, input elen_t b_vs1);
  case (op)
    OP_ADD:  return a_vs2 + b_vs1;
    OP_SUB:  return a_vs2 - b_vs1;
    OP_AND:  return a_vs2 & b_vs1;
    OP_OR:   return a_vs2 | b_vs1;
    OP_XOR:  return a_vs2 ^ b_vs1;
    default: return a_vs2;
  endcase
endfunction

// Snapshot the sources first so vd overlap sees old values
task automatic model_exec(input insn_t insn);
  elen_t src1 [MaxVl];
  elen_t src2 [MaxVl];
  for (int i = 0; i < MaxVl; i++) begin
    src1[i] = model[int'(insn.vs1) * MaxVl + i];
    src2[i] = model[int'(insn.vs2) * MaxVl + i];
  end
  for (int i = 0; i < int'(insn.vl); i++) begin
    model[int'(insn.vd) * MaxVl + i] = alu_ref(insn.op, src2[i], src1[i]);
  end
endtask

task automatic check_elen(input string name, input elen_t exp, input elen_t act);
  if (exp !== act) fail_now($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_count(input string name, input vl_t exp, input vl_t act);
  if (exp !== act) fail_now($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
endtask

`endif

/* testbench/lane_tb.sv */
`timescale 1ns/1ns

module lane_tb;
  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  localparam int unsigned NrBanks = 4;

  logic    clk_i;
  logic    rst_ni;
  insn_t   insn_i;
  logic    insn_valid_i;
  ldu_wr_t ldu_wr_i;
  logic    ldu_wr_valid_i;
  elen_t   stu_data_o;
  logic    stu_valid_o;
  logic    busy_o;
  logic    insn_done_o;

  logic [31:0] rng_state;
  elen_t       model [VrfElems];
  elen_t       stu_q [$];
  string       test_name;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  `include "lane_tb_util.svh"

  lane_top #(.NrBanks(NrBanks)) u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .ldu_wr_i      (ldu_wr_i),
    .ldu_wr_valid_i(ldu_wr_valid_i),
    .stu_data_o    (stu_data_o),
    .stu_valid_o   (stu_valid_o),
    .busy_o        (busy_o),
    .insn_done_o   (insn_done_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic check_idle_outputs();
    if (busy_o || stu_valid_o || insn_done_o)
      fail_now($sformatf("%s: busy, store or done output high while idle", test_name));
  endtask

  task automatic load_elem(input vreg_idx_t vreg, input elem_idx_t elem, input elen_t data);
    @(negedge clk_i);
    ldu_wr_i.vreg  = vreg;
    ldu_wr_i.elem  = elem;
    ldu_wr_i.data  = data;
    ldu_wr_valid_i = 1'b1;
    model[int'(vreg) * MaxVl + int'(elem)] = data;
    @(negedge clk_i);
    ldu_wr_valid_i = 1'b0;
  endtask

  // Issue one instruction and watch the outputs until its done
  task automatic run_insn(input insn_t insn);
    int   cycles;
    vl_t  done_cnt;
    logic done_seen;
    stu_q.delete();
    @(negedge clk_i);
    insn_i       = insn;
    insn_valid_i = 1'b1;
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    cycles    = 0;
    done_cnt  = '0;
    done_seen = 1'b0;
    while (!done_seen) begin
      if (stu_valid_o) stu_q.push_back(stu_data_o);
      if (insn_done_o) begin
        done_seen = 1'b1;
        done_cnt  = done_cnt + vl_t'(1);
        if (busy_o) fail_now($sformatf("%s: busy_o still high with insn_done_o", test_name));
      end else begin
        cycles++;
        if (cycles > 200) fail_now($sformatf("%s: timeout waiting for insn_done_o", test_name));
        @(negedge clk_i);
      end
    end
    // Done must be a single-cycle strobe with nothing trailing it
    @(negedge clk_i);
    if (insn_done_o) done_cnt = done_cnt + vl_t'(1);
    if (stu_valid_o) stu_q.push_back(stu_data_o);
    if (busy_o) fail_now($sformatf("%s: busy_o high after insn_done_o", test_name));
    check_count({test_name, " done pulses"}, vl_t'(1), done_cnt);
    check_count({test_name, " store beats"}, (insn.op == OP_STORE) ? insn.vl : vl_t'(0),
                vl_t'(stu_q.size()));
  endtask

  task automatic store_check(input vreg_idx_t vreg);
    insn_t insn;
    insn     = '0;
    insn.op  = OP_STORE;
    insn.vs2 = vreg;
    insn.vl  = vl_t'(MaxVl);
    run_insn(insn);
    for (int k = 0; k < MaxVl; k++) begin
      check_elen($sformatf("%s v%0d elem %0d", test_name, vreg, k),
                 model[int'(vreg) * MaxVl + k], stu_q[k]);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    insn_t insn;
    int    mode;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    insn_i         = '0;
    insn_valid_i   = 1'b0;
    ldu_wr_i       = '0;
    ldu_wr_valid_i = 1'b0;
    rng_state      = 32'hf62f;
    test_name      = "reset";
    repeat (10) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    rst_ni = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_idle_outputs();
    end

    test_name = "load_store";
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < MaxVl; e++) load_elem(vreg_idx_t'(r), elem_idx_t'(e), rand32());
    end
    for (int r = 0; r < NrVRegs; r++) store_check(vreg_idx_t'(r));

    // Every op under random, vd overlap and same-bank register choices
    for (int i = 0; i < 60; i++) begin
      mode     = (i / 5) % 4;
      insn.op  = alu_op_e'(i % 5);
      insn.vd  = vreg_idx_t'(rand32());
      insn.vs1 = vreg_idx_t'(rand32());
      insn.vs2 = vreg_idx_t'(rand32());
      insn.vl  = vl_t'(1 + rand32() % MaxVl);
      case (mode)
        1: begin
          test_name = "alu_vd_eq_vs1";
          insn.vd   = insn.vs1;
        end
        2: begin
          test_name = "alu_vd_eq_vs2";
          insn.vd   = insn.vs2;
        end
        3: begin
          test_name = "alu_same_bank";
          insn.vs2  = vreg_idx_t'(int'(insn.vs1) + NrBanks);
        end
        default: test_name = "alu_random";
      endcase
      run_insn(insn);
      model_exec(insn);
      store_check(insn.vd);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule : lane_tb

/* design/lane_top.sv */
`timescale 1ns/1ns

module lane_top #(
  parameter  int unsigned NrBanks = 4,
  localparam int unsigned RowW    = $clog2(lane_cfg_pkg::VrfElems / NrBanks)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lane_op_pkg::insn_t  insn_i,
  input  logic                insn_valid_i,
  input  lane_op_pkg::ldu_wr_t ldu_wr_i,
  input  logic                ldu_wr_valid_i,
  output lane_cfg_pkg::elen_t stu_data_o,
  output logic                stu_valid_o,
  output logic                busy_o,
  output logic                insn_done_o
);
  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  if (NrBanks == 0 || (NrBanks & (NrBanks - 1)) != 0 || NrBanks > MaxVl)
    $error("NrBanks must be a power of two no larger than MaxVl");

  ////////////////////////////////////////
  // Sequencer and operand fetch
  ////////////////////////////////////////

  insn_t     seq_insn;
  logic      elem_req, fetch_ready, elem_done;
  elem_idx_t elem_idx;
  vrf_req_t  [1:0] rd_req;
  logic      [1:0] rd_valid, rd_gnt;
  elen_t     [NrBanks-1:0] rd_data;
  vrf_tag_t  [NrBanks-1:0] rd_tag;
  logic      [NrBanks-1:0] rd_data_valid;
  alu_item_t alu_item;
  logic      alu_valid, alu_ready;
  vrf_req_t  wb_req;
  logic      wb_valid, wb_gnt;

  // An element completes on its writeback or its store beat
  assign elem_done = wb_gnt || stu_valid_o;

  lane_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .fetch_ready_i(fetch_ready),
    .elem_done_i  (elem_done),
    .elem_req_o   (elem_req),
    .elem_idx_o   (elem_idx),
    .insn_o       (seq_insn),
    .busy_o       (busy_o),
    .insn_done_o  (insn_done_o)
  );

  operand_fetch #(.NrBanks(NrBanks)) u_fetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .elem_req_i     (elem_req),
    .elem_idx_i     (elem_idx),
    .insn_i         (seq_insn),
    .rd_req_o       (rd_req),
    .rd_valid_o     (rd_valid),
    .rd_gnt_i       (rd_gnt),
    .rd_data_i      (rd_data),
    .rd_tag_i       (rd_tag),
    .rd_data_valid_i(rd_data_valid),
    .alu_item_o     (alu_item),
    .alu_valid_o    (alu_valid),
    .alu_ready_i    (alu_ready),
    .stu_data_o     (stu_data_o),
    .stu_valid_o    (stu_valid_o),
    .fetch_ready_o  (fetch_ready)
  );

  lane_alu u_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .item_i      (alu_item),
    .item_valid_i(alu_valid),
    .item_ready_o(alu_ready),
    .wb_req_o    (wb_req),
    .wb_valid_o  (wb_valid),
    .wb_gnt_i    (wb_gnt)
  );

  ////////////////////////////////////////
  // Register file and its arbiter
  ////////////////////////////////////////

  vrf_req_t ldu_req;
  vrf_req_t [3:0] arb_req;
  logic     [3:0] arb_valid, arb_gnt;
  logic     [NrBanks-1:0] bank_en, bank_we;
  logic     [NrBanks-1:0][RowW-1:0] bank_row;
  elen_t    [NrBanks-1:0] bank_wdata;
  vrf_tag_t [NrBanks-1:0] bank_tag;

  assign ldu_req.we    = 1'b1;
  assign ldu_req.vreg  = ldu_wr_i.vreg;
  assign ldu_req.elem  = ldu_wr_i.elem;
  assign ldu_req.wdata = ldu_wr_i.data;
  assign ldu_req.tag   = '0;

  // Index order is grant priority
  assign arb_req   = {rd_req, wb_req, ldu_req};
  assign arb_valid = {rd_valid, wb_valid, ldu_wr_valid_i};
  assign wb_gnt    = arb_gnt[1];
  assign rd_gnt    = arb_gnt[3:2];

  vrf_bank_arbiter #(.NrBanks(NrBanks)) u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (arb_req),
    .req_valid_i (arb_valid),
    .gnt_o       (arb_gnt),
    .bank_en_o   (bank_en),
    .bank_we_o   (bank_we),
    .bank_row_o  (bank_row),
    .bank_wdata_o(bank_wdata),
    .bank_tag_o  (bank_tag)
  );

  vector_regfile #(.NrBanks(NrBanks)) u_vrf (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .bank_en_i      (bank_en),
    .bank_we_i      (bank_we),
    .bank_row_i     (bank_row),
    .bank_wdata_i   (bank_wdata),
    .bank_tag_i     (bank_tag),
    .rd_data_o      (rd_data),
    .rd_tag_o       (rd_tag),
    .rd_data_valid_o(rd_data_valid)
  );

endmodule : lane_top

/* design/lane_alu.sv */
`timescale 1ns/1ns

module lane_alu (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lane_op_pkg::alu_item_t item_i,
  input  logic                   item_valid_i,
  output logic                   item_ready_o,
  output lane_op_pkg::vrf_req_t  wb_req_o,
  output logic                   wb_valid_o,
  input  logic                   wb_gnt_i
);
  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  elen_t    result;
  logic     full_q;
  vrf_req_t wb_q;
  logic     accept;

  // Sub follows the RVV order, vs2 - vs1
  always_comb begin
    unique case (item_i.op)
      OP_ADD:  result = item_i.vs2_data + item_i.vs1_data;
      OP_SUB:  result = item_i.vs2_data - item_i.vs1_data;
      OP_AND:  result = item_i.vs2_data & item_i.vs1_data;
      OP_OR:   result = item_i.vs2_data | item_i.vs1_data;
      OP_XOR:  result = item_i.vs2_data ^ item_i.vs1_data;
      default: result = item_i.vs2_data;
    endcase
  end

  // One result slot, refilled only once drained
  assign item_ready_o = !full_q;
  assign accept       = item_valid_i && item_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (wb_gnt_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      wb_q.we    <= 1'b1;
      wb_q.vreg  <= item_i.vd;
      wb_q.elem  <= item_i.elem;
      wb_q.wdata <= result;
      wb_q.tag   <= '0;
    end
  end

  assign wb_req_o   = wb_q;
  assign wb_valid_o = full_q;

endmodule : lane_alu

/* design/vector_regfile.sv */
`timescale 1ns/1ns

module vector_regfile #(
  parameter  int unsigned NrBanks = 4,
  localparam int unsigned Depth   = lane_cfg_pkg::VrfElems / NrBanks,
  localparam int unsigned RowW    = $clog2(Depth)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                  [NrBanks-1:0]           bank_en_i,
  input  logic                  [NrBanks-1:0]           bank_we_i,
  input  logic                  [NrBanks-1:0][RowW-1:0] bank_row_i,
  input  lane_cfg_pkg::elen_t   [NrBanks-1:0]           bank_wdata_i,
  input  lane_op_pkg::vrf_tag_t [NrBanks-1:0]           bank_tag_i,
  output lane_cfg_pkg::elen_t   [NrBanks-1:0]           rd_data_o,
  output lane_op_pkg::vrf_tag_t [NrBanks-1:0]           rd_tag_o,
  output logic                  [NrBanks-1:0]           rd_data_valid_o
);
  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  logic [NrFetchPorts-1:0][NrBanks-1:0] tag_hit;

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    elen_t    mem_q [Depth];
    elen_t    rdata_q;
    vrf_tag_t rtag_q;

    always_ff @(posedge clk_i) begin
      if (bank_en_i[b]) begin
        if (bank_we_i[b]) mem_q[bank_row_i[b]] <= bank_wdata_i[b];
        else rdata_q <= mem_q[bank_row_i[b]];
      end
      rtag_q <= bank_tag_i[b];
    end

    assign rd_data_o[b] = rdata_q;
    assign rd_tag_o[b]  = rtag_q;
  end

  // Read data comes back one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_valid_o <= '0;
    end else begin
      rd_data_valid_o <= bank_en_i & ~bank_we_i;
    end
  end

  always_comb begin
    for (int t = 0; t < NrFetchPorts; t++) begin
      for (int b = 0; b < NrBanks; b++) begin
        tag_hit[t][b] = rd_data_valid_o[b] && (rd_tag_o[b] == vrf_tag_t'(t));
      end
    end
  end

  for (genvar t = 0; t < NrFetchPorts; t++) begin : gen_tag_check
    a_one_bank_per_tag: assert property (
      @(posedge clk_i) disable iff (!rst_ni) $onehot0(tag_hit[t])
    );
  end

endmodule : vector_regfile

/* design/vrf_bank_arbiter.sv */
`timescale 1ns/1ns

module vrf_bank_arbiter #(
  parameter  int unsigned NrBanks = 4,
  localparam int unsigned NrReqs  = 4,
  localparam int unsigned RowW    = $clog2(lane_cfg_pkg::VrfElems / NrBanks)
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  lane_op_pkg::vrf_req_t [NrReqs-1:0]           req_i,
  input  logic                  [NrReqs-1:0]           req_valid_i,
  output logic                  [NrReqs-1:0]           gnt_o,
  output logic                  [NrBanks-1:0]          bank_en_o,
  output logic                  [NrBanks-1:0]          bank_we_o,
  output logic                  [NrBanks-1:0][RowW-1:0] bank_row_o,
  output lane_cfg_pkg::elen_t   [NrBanks-1:0]          bank_wdata_o,
  output lane_op_pkg::vrf_tag_t [NrBanks-1:0]          bank_tag_o
);
  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  // Requester 0 is the load port, 1 the ALU writeback, 2 and 3 the fetch ports
  always_comb begin
    int unsigned bank;
    int unsigned flat;
    gnt_o        = '0;
    bank_en_o    = '0;
    bank_we_o    = '0;
    bank_row_o   = '0;
    bank_wdata_o = '0;
    bank_tag_o   = '0;
    // Requesters walked from the highest priority down
    for (int r = 0; r < NrReqs; r++) begin
      flat = int'(req_i[r].vreg) * MaxVl + int'(req_i[r].elem);
      // Neighbouring elements of a register land in neighbouring banks
      bank = (int'(req_i[r].vreg) + int'(req_i[r].elem)) % NrBanks;
      if (req_valid_i[r] && !bank_en_o[bank]) begin
        gnt_o[r]           = 1'b1;
        bank_en_o[bank]    = 1'b1;
        bank_we_o[bank]    = req_i[r].we;
        bank_row_o[bank]   = RowW'(flat / NrBanks);
        bank_wdata_o[bank] = req_i[r].wdata;
        bank_tag_o[bank]   = req_i[r].tag;
      end
    end
  end

  // A request that loses arbitration is held unchanged
  for (genvar r = 1; r < NrReqs; r++) begin : gen_hold_check
    a_req_held: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      req_valid_i[r] && !gnt_o[r] |=> req_valid_i[r] && $stable(req_i[r])
    );
  end

endmodule : vrf_bank_arbiter

/* design/operand_fetch.sv */
`timescale 1ns/1ns

module operand_fetch #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  elem_req_i,
  input  lane_cfg_pkg::elem_idx_t               elem_idx_i,
  input  lane_op_pkg::insn_t                    insn_i,
  output lane_op_pkg::vrf_req_t   [1:0]         rd_req_o,
  output logic                    [1:0]         rd_valid_o,
  input  logic                    [1:0]         rd_gnt_i,
  input  lane_cfg_pkg::elen_t     [NrBanks-1:0] rd_data_i,
  input  lane_op_pkg::vrf_tag_t   [NrBanks-1:0] rd_tag_i,
  input  logic                    [NrBanks-1:0] rd_data_valid_i,
  output lane_op_pkg::alu_item_t                alu_item_o,
  output logic                                  alu_valid_o,
  input  logic                                  alu_ready_i,
  output lane_cfg_pkg::elen_t                   stu_data_o,
  output logic                                  stu_valid_o,
  output logic                                  fetch_ready_o
);
  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  // Port 0 reads vs1, port 1 reads vs2
  logic                          active_q;
  elem_idx_t                     elem_q;
  logic     [NrFetchPorts-1:0]   pend_q;
  logic     [NrFetchPorts-1:0]   have_q;
  elen_t    [NrFetchPorts-1:0]   opnd_q;
  logic     [NrFetchPorts-1:0]   ret_valid;
  elen_t    [NrFetchPorts-1:0]   ret_data;
  logic                          is_store;
  logic                          consume;

  assign is_store = (insn_i.op == OP_STORE);

  always_comb begin
    for (int p = 0; p < NrFetchPorts; p++) begin
      rd_req_o[p].we    = 1'b0;
      rd_req_o[p].vreg  = (p == 0) ? insn_i.vs1 : insn_i.vs2;
      rd_req_o[p].elem  = elem_q;
      rd_req_o[p].wdata = '0;
      rd_req_o[p].tag   = vrf_tag_t'(p);
    end
  end
  assign rd_valid_o = pend_q;

  // Pick up the bank that answers each port
  always_comb begin
    ret_valid = '0;
    ret_data  = '0;
    for (int p = 0; p < NrFetchPorts; p++) begin
      for (int b = 0; b < NrBanks; b++) begin
        if (rd_data_valid_i[b] && (rd_tag_i[b] == vrf_tag_t'(p))) begin
          ret_valid[p] = 1'b1;
          ret_data[p]  = rd_data_i[b];
        end
      end
    end
  end

  // Stores only need vs2
  assign stu_valid_o = active_q && is_store && have_q[1];
  assign stu_data_o  = opnd_q[1];

  assign alu_valid_o         = active_q && !is_store && (&have_q);
  assign alu_item_o.op       = insn_i.op;
  assign alu_item_o.vd       = insn_i.vd;
  assign alu_item_o.elem     = elem_q;
  assign alu_item_o.vs1_data = opnd_q[0];
  assign alu_item_o.vs2_data = opnd_q[1];

  assign consume       = stu_valid_o || (alu_valid_o && alu_ready_i);
  assign fetch_ready_o = !active_q || consume;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      pend_q   <= '0;
      have_q   <= '0;
    end else if (elem_req_i) begin
      active_q <= 1'b1;
      pend_q   <= {1'b1, !is_store};
      have_q   <= '0;
    end else begin
      if (consume) active_q <= 1'b0;
      pend_q <= pend_q & ~rd_gnt_i;
      have_q <= have_q | ret_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (elem_req_i) elem_q <= elem_idx_i;
    for (int p = 0; p < NrFetchPorts; p++) begin
      if (ret_valid[p]) opnd_q[p] <= ret_data[p];
    end
  end

endmodule : operand_fetch

/* design/lane_sequencer.sv */
`timescale 1ns/1ns

module lane_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_op_pkg::insn_t      insn_i,
  input  logic                    insn_valid_i,
  input  logic                    fetch_ready_i,
  input  logic                    elem_done_i,
  output logic                    elem_req_o,
  output lane_cfg_pkg::elem_idx_t elem_idx_o,
  output lane_op_pkg::insn_t      insn_o,
  output logic                    busy_o,
  output logic                    insn_done_o
);
  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} state_e;

  state_e state_q, state_d;
  insn_t  insn_q;
  vl_t    issue_cnt_q;
  vl_t    done_cnt_q;
  logic   issue_last;
  logic   done_last;

  assign busy_o     = (state_q != IDLE);
  assign elem_req_o = (state_q == ISSUE) && fetch_ready_i;
  assign elem_idx_o = elem_idx_t'(issue_cnt_q);
  assign insn_o     = insn_q;

  assign issue_last = (issue_cnt_q + vl_t'(1) == insn_q.vl);
  // Last completion of the instruction
  assign done_last  = (state_q == DRAIN) && elem_done_i && (done_cnt_q + vl_t'(1) == insn_q.vl);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:  if (insn_valid_i) state_d = ISSUE;
      ISSUE: if (elem_req_o && issue_last) state_d = DRAIN;
      DRAIN: if (done_last) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      done_cnt_q  <= '0;
      insn_done_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      insn_done_o <= done_last;
      if (state_q == IDLE) begin
        issue_cnt_q <= '0;
        done_cnt_q  <= '0;
      end else begin
        if (elem_req_o) issue_cnt_q <= issue_cnt_q + vl_t'(1);
        if (elem_done_i) done_cnt_q <= done_cnt_q + vl_t'(1);
      end
    end
  end

  // Instruction stays put until the next one arrives
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && insn_valid_i) insn_q <= insn_i;
  end

  a_no_insn_while_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) insn_valid_i |-> !busy_o
  );

endmodule : lane_sequencer

/* design/lane_op_pkg.sv */
package lane_op_pkg;

  // Operand fetch ports, one per source register
  localparam int unsigned NrFetchPorts = 2;

  // Selects the fetch port that receives read data
  typedef logic [0:0] vrf_tag_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_STORE
  } alu_op_e;

  typedef struct packed {
    alu_op_e                op;
    lane_cfg_pkg::vreg_idx_t vd;
    lane_cfg_pkg::vreg_idx_t vs1;
    lane_cfg_pkg::vreg_idx_t vs2;
    lane_cfg_pkg::vl_t       vl;
  } insn_t;

  // One register file access, read or write
  typedef struct packed {
    logic                    we;
    lane_cfg_pkg::vreg_idx_t vreg;
    lane_cfg_pkg::elem_idx_t elem;
    lane_cfg_pkg::elen_t     wdata;
    vrf_tag_t                tag;
  } vrf_req_t;

  typedef struct packed {
    lane_cfg_pkg::vreg_idx_t vreg;
    lane_cfg_pkg::elem_idx_t elem;
    lane_cfg_pkg::elen_t     data;
  } ldu_wr_t;

  typedef struct packed {
    alu_op_e                 op;
    lane_cfg_pkg::vreg_idx_t vd;
    lane_cfg_pkg::elem_idx_t elem;
    lane_cfg_pkg::elen_t     vs1_data;
    lane_cfg_pkg::elen_t     vs2_data;
  } alu_item_t;

endpackage : lane_op_pkg

/* design/lane_cfg_pkg.sv */
package lane_cfg_pkg;

  ////////////////////////////////////////
  // Lane sizes
  ////////////////////////////////////////

  // Element width in bits
  localparam int unsigned ElenW = 32;

  // Register file shape
  localparam int unsigned NrVRegs  = 8;
  localparam int unsigned MaxVl    = 16;
  localparam int unsigned VrfElems = NrVRegs * MaxVl;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // One element
  typedef logic [ElenW-1:0] elen_t;

  // Register and element indices
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;
  typedef logic [$clog2(MaxVl)-1:0]   elem_idx_t;

  // Vector length, wide enough to hold MaxVl itself
  typedef logic [$clog2(MaxVl):0] vl_t;

endpackage : lane_cfg_pkg
